//--- hw/pdp8_pkg.sv
// ---------------------------------------------------------
// PDP-8 shared types and constants
// ---------------------------------------------------------
package pdp8_pkg;

  localparam int word_w    = 12;
  localparam int addr_w    = 12;
  localparam int mem_words = 4096;

  typedef logic [word_w-1:0] word_t;
  typedef logic [addr_w-1:0] addr_t;

  localparam word_t halt_word = 12'o7402;

  typedef enum logic [2:0] {
    op_and, op_tad, op_isz, op_dca, op_jms, op_jmp, op_iot, op_opr
  } opcode_t;

  typedef enum logic [2:0] {
    cmd_load_pc, cmd_load_ac, cmd_deposit, cmd_examine, cmd_step, cmd_run
  } panel_op_t;

  typedef struct packed {
    panel_op_t op;
    word_t     sr;                                  // Switch register
  } panel_cmd_t;

  typedef struct packed {
    word_t pc;
    word_t ac;
    word_t mb;
    logic  link;
    logic  halted;
  } panel_status_t;

  typedef enum logic [2:0] {ac_hold, ac_clear, ac_load_sr, ac_and, ac_tad} ac_op_t;
  typedef enum logic [1:0] {pc_hold, pc_inc, pc_load_sr, pc_load_ea} pc_op_t;
  typedef enum logic [1:0] {ea_hold, ea_page_zero, ea_curr_page, ea_load_rd} ea_op_t;
  typedef enum logic [1:0] {mb_hold, mb_load_rd, mb_load_wd} mb_op_t;
  typedef enum logic [1:0] {wd_hold, wd_sr, wd_ac} wd_sel_t;
  typedef enum logic [1:0] {ad_hold, ad_pc, ad_sr, ad_ea} ad_sel_t;

  typedef struct packed {
    ac_op_t  ac_op;
    pc_op_t  pc_op;
    ea_op_t  ea_op;
    mb_op_t  mb_op;
    wd_sel_t wd_sel;
    ad_sel_t ad_sel;
    logic    ir_load;
  } dp_ctrl_t;

  typedef struct packed {
    addr_t addr;
    word_t wdata;
    logic  write;
  } mem_req_t;

  typedef enum logic [3:0] {
    st_idle, st_load, st_deposit, st_examine, st_fetch, st_decode, st_addr_calc,
    st_ind_read, st_exec_addr, st_exec_mem, st_exec_fin, st_halt, st_ack
  } cpu_state_t;

  typedef enum logic [1:0] {ph_setup, ph_req, ph_data, ph_done} mem_phase_t;

endpackage

//--- hw/cpu_controller.sv
`timescale 1ns/1ps
// ---------------------------------------------------------
// PDP-8 control sequencer
// ---------------------------------------------------------
module cpu_controller (
  input  logic                 clock,
  input  logic                 resetN,
  input  pdp8_pkg::panel_cmd_t cmd,
  input  logic                 cmd_req,
  output logic                 cmd_ack,
  input  pdp8_pkg::word_t      ir,
  input  logic                 mem_ack,
  output logic                 mem_req_valid,
  output pdp8_pkg::dp_ctrl_t   ctrl,
  output logic                 halted
);

  pdp8_pkg::cpu_state_t state;
  pdp8_pkg::cpu_state_t next_state;
  pdp8_pkg::cpu_state_t after_instr;
  pdp8_pkg::mem_phase_t phase;
  pdp8_pkg::mem_phase_t next_phase;
  pdp8_pkg::opcode_t    op;
  logic                 mem_state;
  logic                 mem_done;

  assign op = pdp8_pkg::opcode_t'(ir[11:9]);
  assign after_instr = (cmd.op == pdp8_pkg::cmd_run) ? pdp8_pkg::st_fetch : pdp8_pkg::st_ack;
  assign mem_state = state inside {pdp8_pkg::st_deposit, pdp8_pkg::st_examine,
                                   pdp8_pkg::st_fetch, pdp8_pkg::st_ind_read,
                                   pdp8_pkg::st_exec_mem};
  assign mem_done = (phase == pdp8_pkg::ph_done) && !mem_ack;  // Ack has dropped
  assign mem_req_valid = mem_state && (phase == pdp8_pkg::ph_req);
  assign cmd_ack = (state == pdp8_pkg::st_ack);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state  <= pdp8_pkg::st_idle;
      phase  <= pdp8_pkg::ph_setup;
      halted <= 1'b0;
    end else begin
      state <= next_state;
      phase <= next_phase;
      if (state == pdp8_pkg::st_halt)
        halted <= 1'b1;
      else if (state == pdp8_pkg::st_idle && cmd_req)
        halted <= 1'b0;                                 // Cleared by the next command
    end
  end

  always_comb begin
    next_state = state;
    next_phase = phase;
    if (mem_state) begin
      case (phase)
        pdp8_pkg::ph_setup: next_phase = pdp8_pkg::ph_req;
        pdp8_pkg::ph_req:   if (mem_ack) next_phase = pdp8_pkg::ph_data;
        pdp8_pkg::ph_data:  next_phase = pdp8_pkg::ph_done;
        default:            if (!mem_ack) next_phase = pdp8_pkg::ph_setup;
      endcase
    end
    case (state)
      pdp8_pkg::st_idle: if (cmd_req) begin
        case (cmd.op)
          pdp8_pkg::cmd_load_pc, pdp8_pkg::cmd_load_ac: next_state = pdp8_pkg::st_load;
          pdp8_pkg::cmd_deposit:                        next_state = pdp8_pkg::st_deposit;
          pdp8_pkg::cmd_examine:                        next_state = pdp8_pkg::st_examine;
          pdp8_pkg::cmd_step, pdp8_pkg::cmd_run:        next_state = pdp8_pkg::st_fetch;
          default:                                      next_state = pdp8_pkg::st_ack;
        endcase
      end
      pdp8_pkg::st_load:     next_state = pdp8_pkg::st_ack;
      pdp8_pkg::st_deposit,
      pdp8_pkg::st_examine:  if (mem_done) next_state = pdp8_pkg::st_ack;
      pdp8_pkg::st_fetch:    if (mem_done) next_state = pdp8_pkg::st_decode;
      pdp8_pkg::st_decode: begin
        if (ir == pdp8_pkg::halt_word)
          next_state = pdp8_pkg::st_halt;
        else if (op inside {pdp8_pkg::op_and, pdp8_pkg::op_tad,
                            pdp8_pkg::op_dca, pdp8_pkg::op_jmp})
          next_state = pdp8_pkg::st_addr_calc;
        else
          next_state = after_instr;                     // Other opcodes act as no-ops
      end
      pdp8_pkg::st_addr_calc:
        next_state = ir[8] ? pdp8_pkg::st_ind_read : pdp8_pkg::st_exec_addr;
      pdp8_pkg::st_ind_read: if (mem_done) next_state = pdp8_pkg::st_exec_addr;
      pdp8_pkg::st_exec_addr: begin
        if (op == pdp8_pkg::op_jmp) begin
          next_state = after_instr;
        end else begin
          next_state = pdp8_pkg::st_exec_mem;
          next_phase = pdp8_pkg::ph_req;                // Address staged here already
        end
      end
      pdp8_pkg::st_exec_mem: if (mem_done) next_state = pdp8_pkg::st_exec_fin;
      pdp8_pkg::st_exec_fin: next_state = after_instr;
      pdp8_pkg::st_halt:     next_state = pdp8_pkg::st_ack;
      pdp8_pkg::st_ack:      if (!cmd_req) next_state = pdp8_pkg::st_idle;
      default:               next_state = pdp8_pkg::st_idle;
    endcase
  end

  always_comb begin
    ctrl = '0;                                          // Hold everything
    case (state)
      pdp8_pkg::st_load: begin
        if (cmd.op == pdp8_pkg::cmd_load_pc) ctrl.pc_op = pdp8_pkg::pc_load_sr;
        if (cmd.op == pdp8_pkg::cmd_load_ac) ctrl.ac_op = pdp8_pkg::ac_load_sr;
      end
      pdp8_pkg::st_deposit: begin
        if (phase == pdp8_pkg::ph_setup) begin
          ctrl.ad_sel = pdp8_pkg::ad_pc;
          ctrl.wd_sel = pdp8_pkg::wd_sr;
        end
        if (phase == pdp8_pkg::ph_data) ctrl.pc_op = pdp8_pkg::pc_inc;
      end
      pdp8_pkg::st_examine: begin
        if (phase == pdp8_pkg::ph_setup) ctrl.ad_sel = pdp8_pkg::ad_sr;
        if (phase == pdp8_pkg::ph_data) ctrl.mb_op = pdp8_pkg::mb_load_rd;
      end
      pdp8_pkg::st_fetch: begin
        if (phase == pdp8_pkg::ph_setup) ctrl.ad_sel = pdp8_pkg::ad_pc;
        if (phase == pdp8_pkg::ph_data) begin
          ctrl.ir_load = 1'b1;
          ctrl.pc_op   = pdp8_pkg::pc_inc;
        end
      end
      pdp8_pkg::st_addr_calc:
        ctrl.ea_op = ir[7] ? pdp8_pkg::ea_curr_page : pdp8_pkg::ea_page_zero;
      pdp8_pkg::st_ind_read: begin
        if (phase == pdp8_pkg::ph_setup) ctrl.ad_sel = pdp8_pkg::ad_ea;
        if (phase == pdp8_pkg::ph_data) ctrl.ea_op = pdp8_pkg::ea_load_rd;  // Pointer word
      end
      pdp8_pkg::st_exec_addr: begin
        if (op == pdp8_pkg::op_jmp) begin
          ctrl.pc_op = pdp8_pkg::pc_load_ea;
        end else begin
          ctrl.ad_sel = pdp8_pkg::ad_ea;
          if (op == pdp8_pkg::op_dca) ctrl.wd_sel = pdp8_pkg::wd_ac;
        end
      end
      pdp8_pkg::st_exec_mem:
        if (phase == pdp8_pkg::ph_data)
          ctrl.mb_op = (op == pdp8_pkg::op_dca) ? pdp8_pkg::mb_load_wd : pdp8_pkg::mb_load_rd;
      pdp8_pkg::st_exec_fin: begin
        case (op)
          pdp8_pkg::op_and: ctrl.ac_op = pdp8_pkg::ac_and;
          pdp8_pkg::op_tad: ctrl.ac_op = pdp8_pkg::ac_tad;
          default:          ctrl.ac_op = pdp8_pkg::ac_clear;  // DCA
        endcase
      end
      default: ;
    endcase
  end

endmodule

//--- hw/cpu_datapath.sv
`timescale 1ns/1ps
// ---------------------------------------------------------
// PDP-8 register datapath
// ---------------------------------------------------------
module cpu_datapath (
  input  logic                    clock,
  input  logic                    resetN,
  input  pdp8_pkg::dp_ctrl_t      ctrl,
  input  pdp8_pkg::word_t         sr,
  input  pdp8_pkg::word_t         rdata,
  output pdp8_pkg::mem_req_t      mem_req,
  output pdp8_pkg::word_t         ir,
  output pdp8_pkg::panel_status_t status
);

  pdp8_pkg::word_t ac;
  pdp8_pkg::word_t mb;
  pdp8_pkg::word_t wdata;
  pdp8_pkg::addr_t pc;
  pdp8_pkg::addr_t ea;
  pdp8_pkg::addr_t addr;
  logic            link;
  logic            write;
  logic [pdp8_pkg::word_w:0] tad_sum;

  assign tad_sum = {1'b0, ac} + {1'b0, mb};             // Top bit is the carry out

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      ac    <= '0;
      link  <= 1'b0;
      pc    <= '0;
      ir    <= '0;
      ea    <= '0;
      mb    <= '0;
      addr  <= '0;
      wdata <= '0;
      write <= 1'b0;
    end else begin
      case (ctrl.ac_op)
        pdp8_pkg::ac_clear:   ac <= '0;
        pdp8_pkg::ac_load_sr: ac <= sr;
        pdp8_pkg::ac_and:     ac <= ac & mb;
        pdp8_pkg::ac_tad: begin
          ac   <= tad_sum[pdp8_pkg::word_w-1:0];
          link <= link ^ tad_sum[pdp8_pkg::word_w];
        end
        default: ;
      endcase
      case (ctrl.pc_op)
        pdp8_pkg::pc_inc:     pc <= pc + 1'b1;
        pdp8_pkg::pc_load_sr: pc <= sr;
        pdp8_pkg::pc_load_ea: pc <= ea;
        default: ;
      endcase
      case (ctrl.ea_op)
        pdp8_pkg::ea_page_zero: ea <= {5'b0, ir[6:0]};
        pdp8_pkg::ea_curr_page: ea <= {pc[11:7], ir[6:0]};  // PC already past the instruction
        pdp8_pkg::ea_load_rd:   ea <= rdata;
        default: ;
      endcase
      case (ctrl.mb_op)
        pdp8_pkg::mb_load_rd: mb <= rdata;
        pdp8_pkg::mb_load_wd: mb <= wdata;
        default: ;
      endcase
      case (ctrl.wd_sel)
        pdp8_pkg::wd_sr: wdata <= sr;
        pdp8_pkg::wd_ac: wdata <= ac;
        default: ;
      endcase
      case (ctrl.ad_sel)
        pdp8_pkg::ad_pc: addr <= pc;
        pdp8_pkg::ad_sr: addr <= sr;
        pdp8_pkg::ad_ea: addr <= ea;
        default: ;
      endcase
      // Staging write data alongside the address marks the access as a write
      if (ctrl.ad_sel != pdp8_pkg::ad_hold)
        write <= (ctrl.wd_sel != pdp8_pkg::wd_hold);
      if (ctrl.ir_load)
        ir <= rdata;
    end
  end

  assign mem_req = '{addr: addr, wdata: wdata, write: write};
  assign status  = '{pc: pc, ac: ac, mb: mb, link: link, halted: 1'b0};  // Halt flag kept by controller

endmodule

//--- hw/core_memory.sv
`timescale 1ns/1ps
// ---------------------------------------------------------
// PDP-8 core memory
// ---------------------------------------------------------
module core_memory (
  input  logic               clock,
  input  logic               resetN,
  input  pdp8_pkg::mem_req_t mem_req,
  input  logic               mem_req_valid,
  output logic               mem_ack,
  output pdp8_pkg::word_t    rdata
);

  pdp8_pkg::word_t mem [pdp8_pkg::mem_words];
  logic            start;

  assign start = mem_req_valid && !mem_ack;             // First cycle of a request

  // Ack follows the request by one cycle in both directions
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN)
      mem_ack <= 1'b0;
    else
      mem_ack <= mem_req_valid;
  end

  always_ff @(posedge clock) begin
    if (start) begin
      if (mem_req.write)
        mem[mem_req.addr] <= mem_req.wdata;
      rdata <= mem[mem_req.addr];                       // Held until the next access
    end
  end

endmodule

//--- hw/pdp8_top.sv
`timescale 1ns/1ps
// ---------------------------------------------------------
// PDP-8 processor with front panel
// ---------------------------------------------------------
module pdp8_top (
  input  logic                    clock,
  input  logic                    resetN,
  input  pdp8_pkg::panel_cmd_t    cmd,
  input  logic                    cmd_req,
  output logic                    cmd_ack,
  output pdp8_pkg::panel_status_t status
);

  pdp8_pkg::dp_ctrl_t      ctrl;
  pdp8_pkg::mem_req_t      mem_req;
  pdp8_pkg::word_t         rdata;
  pdp8_pkg::word_t         ir;
  pdp8_pkg::panel_status_t dp_status;
  logic                    mem_req_valid;
  logic                    mem_ack;
  logic                    halted;

  cpu_controller cpu_controller_i (
    .clock, .resetN,
    .cmd, .cmd_req, .cmd_ack,
    .ir, .mem_ack, .mem_req_valid,
    .ctrl, .halted
  );

  cpu_datapath cpu_datapath_i (
    .clock, .resetN,
    .ctrl, .sr(cmd.sr), .rdata,
    .mem_req, .ir, .status(dp_status)
  );

  core_memory core_memory_i (
    .clock, .resetN,
    .mem_req, .mem_req_valid, .mem_ack, .rdata
  );

  assign status = '{pc: dp_status.pc, ac: dp_status.ac, mb: dp_status.mb,
                    link: dp_status.link, halted: halted};

endmodule

//--- verification/pdp8_sva.sv
`timescale 1ns/1ps
// ---------------------------------------------------------
// Handshake assertions
// ---------------------------------------------------------
module pdp8_sva (
  input logic               clock,
  input logic               resetN,
  input logic               cmd_req,
  input logic               cmd_ack,
  input logic               mem_req_valid,
  input logic               mem_ack,
  input pdp8_pkg::mem_req_t mem_req
);

  payload_stable: assert property (@(posedge clock) disable iff (!resetN)
    mem_req_valid && $past(mem_req_valid) |-> $stable(mem_req))
    else $error("Memory request payload changed while the request was high");

  // Controller must have seen the previous ack low
  no_req_during_ack: assert property (@(posedge clock) disable iff (!resetN)
    $rose(mem_req_valid) |-> $past(!mem_ack))
    else $error("Memory request raised while the previous ack was still high");

  // Request drops after the ack, ack follows within two cycles
  ack_release: assert property (@(posedge clock) disable iff (!resetN)
    mem_req_valid && mem_ack |=> !mem_req_valid ##[0:1] !mem_ack)
    else $error("Memory ack still high two cycles after the request fell");

  cmd_ack_needs_req: assert property (@(posedge clock) disable iff (!resetN)
    cmd_ack |-> cmd_req || $past(cmd_req))
    else $error("Panel ack without a panel request");

endmodule

//--- verification/pdp8_checker.sv
`timescale 1ns/1ps
// ---------------------------------------------------------
// Panel status checker
// ---------------------------------------------------------
module pdp8_checker (
  input  logic                    clock,
  input  logic                    resetN,
  input  logic                    cmd_ack,
  input  pdp8_pkg::panel_cmd_t    cmd,
  input  pdp8_pkg::panel_status_t status,
  input  pdp8_pkg::panel_status_t expected,
  input  logic                    done,
  output int                      tests,
  output int                      errors
);

  logic                ack_d;
  logic                done_d;
  logic                reset_seen;
  int                  bad;
  string               label;
  pdp8_pkg::panel_op_t op_seen;

  function automatic int compare_field(string name, pdp8_pkg::word_t exp, pdp8_pkg::word_t act);
    if (exp === act)
      return 0;
    $display("[ERROR] %0t %s expected %04o actual %04o", $time, name, exp, act);
    return 1;
  endfunction

  function automatic int compare_status(pdp8_pkg::panel_status_t exp);
    int n;
    n = compare_field("status.pc", exp.pc, status.pc);
    n += compare_field("status.ac", exp.ac, status.ac);
    n += compare_field("status.mb", exp.mb, status.mb);
    n += compare_field("status.link", 12'(exp.link), 12'(status.link));
    n += compare_field("status.halted", 12'(exp.halted), 12'(status.halted));
    return n;
  endfunction

  always @(posedge clock) begin
    if (!resetN) begin
      ack_d      <= 1'b0;
      done_d     <= 1'b0;
      reset_seen <= 1'b0;
      tests      <= 0;
      errors     <= 0;
    end else begin
      ack_d  <= cmd_ack;
      done_d <= done;
      if (!reset_seen || (cmd_ack && !ack_d)) begin
        if (!reset_seen) begin
          label = "reset";
          bad   = compare_status('0) + compare_field("cmd_ack", 12'd0, 12'(cmd_ack));
        end else begin
          op_seen = cmd.op;
          label   = op_seen.name();
          bad     = compare_status(expected);
        end
        reset_seen <= 1'b1;
        tests      <= tests + 1;
        if (bad != 0)
          errors <= errors + 1;
        $display("test %0d %s sr=%04o: %s", tests + 1, label, cmd.sr,
                 (bad == 0) ? "ok" : "mismatch");
      end
      if (done && !done_d)
        $display("%0d tests, %0d passed, %0d failed", tests, tests - errors, errors);
    end
  end

endmodule

//--- verification/pdp8_tb.sv
`timescale 1ns/1ps
// ---------------------------------------------------------
// PDP-8 front panel testbench
// ---------------------------------------------------------
module pdp8_tb;

  localparam int n_prog = 16;
  localparam int n_exam = 8;
  localparam int n_data = 16;
  localparam int n_step = 24;
  localparam int n_run  = 6;
  // Commands issued by the four test tasks
  localparam int n_cmds = (1 + n_prog + n_exam) + (2 * n_data + 2 * n_step + 5) + 16
                          + (n_run + 14);

  logic                    clock;
  logic                    resetN;
  logic                    cmd_req;
  logic                    cmd_ack;
  logic                    done;
  pdp8_pkg::panel_cmd_t    cmd;
  pdp8_pkg::panel_status_t status;
  pdp8_pkg::panel_status_t expected;
  int                      tests;
  int                      errors;
  int                      n_sent;
  int                      seed;

  pdp8_pkg::word_t m_mem [pdp8_pkg::mem_words];        // Reference model
  pdp8_pkg::word_t m_pc;
  pdp8_pkg::word_t m_ac;
  pdp8_pkg::word_t m_mb;
  logic            m_link;
  logic            m_halted;

  pdp8_top pdp8_top_i (.clock, .resetN, .cmd, .cmd_req, .cmd_ack, .status);

  pdp8_checker pdp8_checker_i (
    .clock, .resetN, .cmd_ack, .cmd, .status, .expected, .done, .tests, .errors
  );

  bind pdp8_top pdp8_sva pdp8_sva_i (
    .clock, .resetN, .cmd_req, .cmd_ack, .mem_req_valid, .mem_ack, .mem_req
  );

  always #2 clock = ~clock;

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  // Memory reference ops and no-op classes mixed 50/50
  function automatic pdp8_pkg::word_t program_word(logic [31:0] r);
    logic [2:0] op;
    case (r[13:12])
      2'd0:    op = r[15] ? 3'o2 : 3'o0;
      2'd1:    op = r[15] ? 3'o4 : 3'o1;
      2'd2:    op = r[15] ? 3'o6 : 3'o3;
      default: op = r[15] ? 3'o7 : 3'o5;
    endcase
    return {op, r[8:0]};
  endfunction

  task automatic exec_instr();
    pdp8_pkg::word_t inst;
    pdp8_pkg::word_t ea;
    logic            carry;
    inst = m_mem[m_pc];
    m_pc = m_pc + 12'd1;
    ea   = inst[7] ? {m_pc[11:7], inst[6:0]} : {5'b0, inst[6:0]};
    if (inst == pdp8_pkg::halt_word) begin
      m_halted = 1'b1;
    end else if (inst[11:9] inside {3'o0, 3'o1, 3'o3, 3'o5}) begin
      if (inst[8])
        ea = m_mem[ea];
      case (inst[11:9])
        3'o0: begin
          m_mb = m_mem[ea];
          m_ac = m_ac & m_mb;
        end
        3'o1: begin
          m_mb = m_mem[ea];
          {carry, m_ac} = {1'b0, m_ac} + {1'b0, m_mb};
          m_link = m_link ^ carry;
        end
        3'o3: begin
          m_mem[ea] = m_ac;
          m_mb      = m_ac;
          m_ac      = '0;
        end
        default: m_pc = ea;                            // JMP
      endcase
    end
  endtask

  task automatic model_apply(input pdp8_pkg::panel_op_t op, input pdp8_pkg::word_t sr);
    int count;
    m_halted = 1'b0;
    count    = 0;
    case (op)
      pdp8_pkg::cmd_load_pc: m_pc = sr;
      pdp8_pkg::cmd_load_ac: m_ac = sr;
      pdp8_pkg::cmd_deposit: begin
        m_mem[m_pc] = sr;
        m_pc        = m_pc + 12'd1;
      end
      pdp8_pkg::cmd_examine: m_mb = m_mem[sr];
      pdp8_pkg::cmd_step:    exec_instr();
      pdp8_pkg::cmd_run: begin
        while (!m_halted && count < 1000) begin
          exec_instr();
          count++;
        end
      end
      default: ;
    endcase
  endtask

  task automatic send_command(input pdp8_pkg::panel_op_t op, input pdp8_pkg::word_t sr);
    model_apply(op, sr);
    @(posedge clock);
    cmd      <= '{op: op, sr: sr};
    cmd_req  <= 1'b1;
    expected <= '{pc: m_pc, ac: m_ac, mb: m_mb, link: m_link, halted: m_halted};
    n_sent++;
    @(posedge clock);
    while (!cmd_ack) @(posedge clock);
    cmd_req <= 1'b0;
    @(posedge clock);
    while (cmd_ack) @(posedge clock);
  endtask

  task automatic fill_random(input pdp8_pkg::addr_t base, input int n);
    logic [31:0] r;
    send_command(pdp8_pkg::cmd_load_pc, base);
    for (int i = 0; i < n; i++) begin
      r = rand32();
      send_command(pdp8_pkg::cmd_deposit, r[11:0]);
    end
  endtask

  task automatic load_examine_test();
    pdp8_pkg::addr_t base;
    logic [31:0]     r;
    r    = rand32();
    base = 12'o2000 + {3'b0, r[8:0]};
    send_command(pdp8_pkg::cmd_load_pc, base);
    for (int i = 0; i < n_prog; i++)
      send_command(pdp8_pkg::cmd_deposit, program_word(rand32()));
    for (int i = 0; i < n_exam; i++) begin
      r = rand32();
      send_command(pdp8_pkg::cmd_examine, base + 12'(r % n_prog));
    end
  endtask

  // Operands at 0020 on page zero and 4140 on the code page
  task automatic step_test();
    logic [31:0] r;
    fill_random(12'o0020, n_data);
    fill_random(12'o4140, n_data);
    send_command(pdp8_pkg::cmd_load_pc, 12'o4000);
    for (int i = 0; i < n_step; i++) begin
      r = rand32();
      send_command(pdp8_pkg::cmd_deposit, {2'b00, r[0], 1'b0, r[1],
                   r[1] ? 7'o140 + {3'b0, r[5:2]} : 7'o020 + {3'b0, r[5:2]}});
    end
    send_command(pdp8_pkg::cmd_load_pc, 12'o4000);
    r = rand32();
    send_command(pdp8_pkg::cmd_load_ac, r[11:0]);
    repeat (n_step) send_command(pdp8_pkg::cmd_step, '0);
  endtask

  task automatic indirect_test();
    pdp8_pkg::addr_t target;
    logic [31:0]     r;
    r      = rand32();
    target = 12'o6000 + {5'b0, r[6:0]};
    send_command(pdp8_pkg::cmd_load_pc, 12'o0040);
    send_command(pdp8_pkg::cmd_deposit, target);
    fill_random(target, 1);
    send_command(pdp8_pkg::cmd_load_pc, 12'o4200);
    send_command(pdp8_pkg::cmd_deposit, 12'o1440);     // TAD I 0040
    send_command(pdp8_pkg::cmd_deposit, 12'o3440);     // DCA I 0040
    send_command(pdp8_pkg::cmd_deposit, 12'o1650);     // TAD I via 4250
    send_command(pdp8_pkg::cmd_load_pc, 12'o4250);
    send_command(pdp8_pkg::cmd_deposit, target);
    send_command(pdp8_pkg::cmd_load_pc, 12'o4200);
    r = rand32();
    send_command(pdp8_pkg::cmd_load_ac, r[11:0]);
    repeat (3) send_command(pdp8_pkg::cmd_step, '0);
    send_command(pdp8_pkg::cmd_examine, target);
  endtask

  task automatic run_test();
    logic [31:0] r;
    send_command(pdp8_pkg::cmd_load_pc, 12'o0041);
    send_command(pdp8_pkg::cmd_deposit, 12'o5400);     // Pointer to the halt block
    send_command(pdp8_pkg::cmd_load_pc, 12'o5000);
    for (int i = 0; i < n_run; i++) begin
      r = rand32();
      send_command(pdp8_pkg::cmd_deposit, {2'b00, r[0], 2'b00, 7'o020 + {3'b0, r[5:2]}});
    end
    r = rand32();
    send_command(pdp8_pkg::cmd_deposit, {3'o6, r[8:0]});
    send_command(pdp8_pkg::cmd_deposit, 12'o3060);     // DCA 0060
    send_command(pdp8_pkg::cmd_deposit, 12'o1060);     // TAD 0060
    send_command(pdp8_pkg::cmd_deposit, 12'o5441);     // JMP I 0041
    send_command(pdp8_pkg::cmd_load_pc, 12'o5400);
    send_command(pdp8_pkg::cmd_deposit, 12'o7001);
    r = rand32();
    send_command(pdp8_pkg::cmd_deposit, {5'b00100, 7'o020 + {3'b0, r[5:2]}});
    send_command(pdp8_pkg::cmd_deposit, pdp8_pkg::halt_word);
    send_command(pdp8_pkg::cmd_load_pc, 12'o5000);
    r = rand32();
    send_command(pdp8_pkg::cmd_load_ac, r[11:0]);
    send_command(pdp8_pkg::cmd_run, '0);
  endtask

  initial begin
    seed     = 25626;
    clock    = 1'b0;
    resetN   = 1'b0;
    cmd_req  = 1'b0;
    cmd      = '0;
    expected = '0;
    done     = 1'b0;
    n_sent   = 0;
    m_pc     = '0;
    m_ac     = '0;
    m_mb     = '0;
    m_link   = 1'b0;
    m_halted = 1'b0;
    repeat (16) @(posedge clock);
    resetN <= 1'b1;
    repeat (2) @(posedge clock);
    load_examine_test();
    step_test();
    indirect_test();
    run_test();
    done <= 1'b1;
    repeat (2) @(posedge clock);
    if (errors == 0 && tests == n_sent + 1) begin
      $display("TEST PASSED");
    end else begin
      if (tests != n_sent + 1)
        $display("Checker saw %0d results for %0d commands plus reset", tests, n_sent);
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog, 200 cycles per command plus reset
  initial begin
    repeat (n_cmds * 200 + 32) @(posedge clock);
    $display("Timeout: panel commands still pending after %0d cycles", n_cmds * 200 + 32);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- compile.f
hw/pdp8_pkg.sv
hw/cpu_controller.sv
hw/cpu_datapath.sv
hw/core_memory.sv
hw/pdp8_top.sv
verification/pdp8_sva.sv
verification/pdp8_checker.sv
verification/pdp8_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the PDP-8 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module pdp8_tb \
  --Mdir obj_dir -o pdp8_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/pdp8_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0
